//--- hdl/tcb_params.svh
// TCB interconnect sizes and per-subordinate wildcard decode patterns
`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// bus sizes
////////////////////////////////////////////////////////////////////////////

// byte address width
`define TCB_ADR 32
// data width, four byte lanes
`define TCB_DAT 32
// byte enable width
`define TCB_BEN (`TCB_DAT/8)

////////////////////////////////////////////////////////////////////////////
// interconnect
////////////////////////////////////////////////////////////////////////////

// number of memory subordinates
`define TCB_IFN 4
// words per subordinate, 256 byte window
`define TCB_MEM_DEPTH 64

// wildcard address patterns, x bits are don't care
// bits 9:8 pick the window
// bits 7:0 are the offset inside the window
// upper bits must be zero or the access misses
`define TCB_DAM0 32'h0000_00xx
`define TCB_DAM1 32'h0000_01xx
`define TCB_DAM2 32'h0000_02xx
`define TCB_DAM3 32'h0000_03xx

`endif

//--- hdl/tcb_pkg.sv
// TCB package with the request operation and response status types
`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////////

  // request operation
  // single bit on the bus
  typedef enum logic {
    TCB_RD = 1'b0,  // read
    TCB_WR = 1'b1   // write with byte enables
  } tcb_op_t;

  //////////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////////

  // response status
  // decode error comes back with zero data
  typedef enum logic {
    TCB_OK     = 1'b0,  // address hit a subordinate
    TCB_DECERR = 1'b1   // no pattern matched
  } tcb_sts_t;

endpackage : tcb_pkg

`default_nettype wire

//--- hdl/tcb_lib_decoder.sv
// TCB wildcard address decoder giving a subordinate index and a hit flag
`timescale 1ns/1ps
`default_nettype none

module tcb_lib_decoder
  import tcb_pkg::*;
#(
  // address width
  parameter  int unsigned    ADR = 32,
  // number of subordinates
  parameter  int unsigned    IFN = 4,
  // index width
  localparam int unsigned    IFL = $clog2(IFN),
  // address/mask patterns, one per subordinate
  parameter  logic [ADR-1:0] DAM [IFN-1:0] = '{default: '0}
)(
  input  logic [ADR-1:0] adr,  // request address
  output logic [IFL-1:0] sel,  // selected subordinate
  output logic           hit   // some pattern matched
);

////////////////////////////////////////////////////////////////////////////
// pattern match
////////////////////////////////////////////////////////////////////////////

  // one match bit per subordinate
  logic [IFN-1:0] mch;

  // wildcard compare
  // x bits in the pattern match anything
  generate
    for (genvar i = 0; i < IFN; i++) begin : g_mch
      assign mch[i] = (adr ==? DAM[i]);
    end
  endgenerate

////////////////////////////////////////////////////////////////////////////
// priority encode
////////////////////////////////////////////////////////////////////////////

  // lowest matching index wins
  // walk down so the lowest hit is written last
  function automatic logic [IFL-1:0] encode (logic [IFN-1:0] val);
    logic [IFL-1:0] idx;
    idx = '0;
    for (int i = IFN-1; i >= 0; i--) begin
      if (val[i]) begin
        idx = i[IFL-1:0];
      end
    end
    return idx;
  endfunction : encode

  // index is zero on a miss
  assign sel = encode(mch);

  // any match
  assign hit = |mch;

endmodule : tcb_lib_decoder

`default_nettype wire

//--- hdl/tcb_lib_demux.sv
// TCB request demux with strobe fan-out and response path registers
`timescale 1ns/1ps
`default_nettype none

`include "tcb_params.svh"

module tcb_lib_demux
  import tcb_pkg::*;
#(
  // index width
  localparam int unsigned IFL = $clog2(`TCB_IFN)
)(
  input  logic               clk,
  input  logic               rst_n,
  // request strobe from the manager
  input  logic               req_vld,
  // decoder result
  input  logic [IFL-1:0]     sel,
  input  logic               hit,
  // per-subordinate request strobes
  output logic [`TCB_IFN-1:0] sub_vld,
  // response path, one cycle behind the request
  output logic               rsp_pend,
  output logic [IFL-1:0]     rsp_sel,
  output logic               rsp_hit
);

////////////////////////////////////////////////////////////////////////////
// request strobes
////////////////////////////////////////////////////////////////////////////

  // one-hot decode of sel
  // nothing goes out on a miss
  always_comb begin
    for (int i = 0; i < `TCB_IFN; i++) begin
      sub_vld[i] = req_vld && hit && (sel == i[IFL-1:0]);
    end
  end

////////////////////////////////////////////////////////////////////////////
// response tracking
////////////////////////////////////////////////////////////////////////////

  // every request gets exactly one response
  // hit or miss alike
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_pend <= 1'b0;
      rsp_sel  <= '0;
      rsp_hit  <= 1'b0;
    end else begin
      rsp_pend <= req_vld;
      // hold the last selection when idle
      if (req_vld) begin
        rsp_sel <= sel;
        rsp_hit <= hit;
      end
    end
  end

endmodule : tcb_lib_demux

`default_nettype wire

//--- hdl/tcb_mem_sub.sv
// TCB memory subordinate with byte-enabled writes and a registered read
`timescale 1ns/1ps
`default_nettype none

`include "tcb_params.svh"

module tcb_mem_sub
  import tcb_pkg::*;
#(
  // word index width
  localparam int unsigned MAW = $clog2(`TCB_MEM_DEPTH)
)(
  input  logic                clk,
  input  logic                rst_n,
  // request
  input  logic                vld,  // strobe for this window
  input  tcb_op_t             op,   // read or write
  input  logic [`TCB_ADR-1:0] adr,  // byte address
  input  logic [`TCB_BEN-1:0] ben,  // byte enables
  input  logic [`TCB_DAT-1:0] wdt,  // write data
  // response
  output logic [`TCB_DAT-1:0] rdt   // read data, one cycle later
);

////////////////////////////////////////////////////////////////////////////
// storage
////////////////////////////////////////////////////////////////////////////

  // word array
  logic [`TCB_DAT-1:0] mem [0:`TCB_MEM_DEPTH-1];

  // word index from bits 7:2
  logic [MAW-1:0] idx;

  assign idx = adr[MAW+1:2];

////////////////////////////////////////////////////////////////////////////
// write port
////////////////////////////////////////////////////////////////////////////

  // only the enabled lanes change
  // lands at the request edge
  always_ff @(posedge clk) begin
    if (vld && (op == TCB_WR)) begin
      for (int b = 0; b < `TCB_BEN; b++) begin
        if (ben[b]) begin
          mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// read port
////////////////////////////////////////////////////////////////////////////

  // registered read
  // holds between reads
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdt <= '0;
    end else if (vld && (op == TCB_RD)) begin
      rdt <= mem[idx];
    end
  end

endmodule : tcb_mem_sub

`default_nettype wire

//--- hdl/tcb_lib_mux.sv
// TCB response mux picking subordinate read data and forming the status
`timescale 1ns/1ps
`default_nettype none

`include "tcb_params.svh"

module tcb_lib_mux
  import tcb_pkg::*;
#(
  // index width
  localparam int unsigned IFL = $clog2(`TCB_IFN)
)(
  // response tracking from the demux
  input  logic                rsp_pend,
  input  logic [IFL-1:0]      rsp_sel,
  input  logic                rsp_hit,
  // registered read data of all subordinates
  input  logic [`TCB_DAT-1:0] sub_rdt [`TCB_IFN-1:0],
  // manager response
  output logic                rsp_vld,
  output logic [`TCB_DAT-1:0] rsp_rdt,
  output tcb_sts_t            rsp_sts
);

////////////////////////////////////////////////////////////////////////////
// response strobe
////////////////////////////////////////////////////////////////////////////

  // fixed latency
  // the pending flag is the strobe
  assign rsp_vld = rsp_pend;

////////////////////////////////////////////////////////////////////////////
// data and status
////////////////////////////////////////////////////////////////////////////

  // selected window on a hit
  // zero data on a miss
  always_comb begin
    if (rsp_hit) begin
      rsp_rdt = sub_rdt[rsp_sel];
      rsp_sts = TCB_OK;
    end else begin
      rsp_rdt = '0;
      rsp_sts = TCB_DECERR;
    end
  end

endmodule : tcb_lib_mux

`default_nettype wire

//--- hdl/tcb_ic_top.sv
// TCB interconnect top with decoder, demux, four memory subordinates and mux
`timescale 1ns/1ps
`default_nettype none

`include "tcb_params.svh"

module tcb_ic_top
  import tcb_pkg::*;
#(
  // index width
  localparam int unsigned IFL = $clog2(`TCB_IFN)
)(
  input  logic                clk,
  input  logic                rst_n,
  // manager request
  input  logic                req_vld,
  input  tcb_op_t             req_op,
  input  logic [`TCB_ADR-1:0] req_adr,
  input  logic [`TCB_BEN-1:0] req_ben,
  input  logic [`TCB_DAT-1:0] req_wdt,
  // manager response
  output logic                rsp_vld,
  output logic [`TCB_DAT-1:0] rsp_rdt,
  output tcb_sts_t            rsp_sts
);

////////////////////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////////////////////

  // decode patterns, index 0 on the right
  localparam logic [`TCB_ADR-1:0] DAM [`TCB_IFN-1:0] = '{
    `TCB_DAM3, `TCB_DAM2, `TCB_DAM1, `TCB_DAM0
  };

  // decoder result
  logic [IFL-1:0]      sel;
  logic                hit;

  // per-window strobes
  logic [`TCB_IFN-1:0] sub_vld;

  // response tracking
  logic                rsp_pend;
  logic [IFL-1:0]      rsp_sel;
  logic                rsp_hit;

  // read data per window
  logic [`TCB_DAT-1:0] sub_rdt [`TCB_IFN-1:0];

////////////////////////////////////////////////////////////////////////////
// request path
////////////////////////////////////////////////////////////////////////////

  // address decode
  tcb_lib_decoder #(
    .ADR (`TCB_ADR),
    .IFN (`TCB_IFN),
    .DAM (DAM)
  ) tcb_lib_decoder_inst (
    .adr (req_adr),
    .sel (sel),
    .hit (hit)
  );

  // strobe routing and response tracking
  tcb_lib_demux tcb_lib_demux_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_vld  (req_vld),
    .sel      (sel),
    .hit      (hit),
    .sub_vld  (sub_vld),
    .rsp_pend (rsp_pend),
    .rsp_sel  (rsp_sel),
    .rsp_hit  (rsp_hit)
  );

////////////////////////////////////////////////////////////////////////////
// subordinates
////////////////////////////////////////////////////////////////////////////

  // payload fans out to every window
  // only the strobe is per window
  generate
    for (genvar i = 0; i < `TCB_IFN; i++) begin : g_sub
      tcb_mem_sub tcb_mem_sub_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .vld   (sub_vld[i]),
        .op    (req_op),
        .adr   (req_adr),
        .ben   (req_ben),
        .wdt   (req_wdt),
        .rdt   (sub_rdt[i])
      );
    end
  endgenerate

////////////////////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////////////////////

  tcb_lib_mux tcb_lib_mux_inst (
    .rsp_pend (rsp_pend),
    .rsp_sel  (rsp_sel),
    .rsp_hit  (rsp_hit),
    .sub_rdt  (sub_rdt),
    .rsp_vld  (rsp_vld),
    .rsp_rdt  (rsp_rdt),
    .rsp_sts  (rsp_sts)
  );

endmodule : tcb_ic_top

`default_nettype wire

//--- verif/tcb_ic_checker.sv
// TCB interconnect checker with a shadow memory and response assertions
`timescale 1ns/1ps
`default_nettype none

`include "tcb_params.svh"

module tcb_ic_checker
  import tcb_pkg::*;
(
  input logic                clk,
  input logic                rst_n,
  // manager request
  input logic                req_vld,
  input tcb_op_t             req_op,
  input logic [`TCB_ADR-1:0] req_adr,
  input logic [`TCB_BEN-1:0] req_ben,
  input logic [`TCB_DAT-1:0] req_wdt,
  // manager response
  input logic                rsp_vld,
  input logic [`TCB_DAT-1:0] rsp_rdt,
  input tcb_sts_t            rsp_sts
);

////////////////////////////////////////////////////////////////////////////
// shadow memory and prediction
////////////////////////////////////////////////////////////////////////////

  // failed checks so far
  int unsigned err_cnt = 0;

  // whole 1 KiB map, one entry per byte
  logic [7:0] shadow [0:1023];

  // response expected at the next edge
  logic                exp_dat;
  logic [`TCB_DAT-1:0] exp_rdt;
  tcb_sts_t            exp_sts;

  // valid map is 0x000 to 0x3ff
  logic       in_map;
  logic [7:0] wrd;

  assign in_map = (req_adr[`TCB_ADR-1:10] == '0);
  assign wrd    = req_adr[9:2];

  // data is only defined for reads and misses
  // a write hit returns whatever the window last read
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_dat <= 1'b0;
      exp_rdt <= '0;
      exp_sts <= TCB_OK;
    end else begin
      if (req_vld && !in_map) begin
        exp_sts <= TCB_DECERR;
        exp_rdt <= '0;
        exp_dat <= 1'b1;
      end else if (req_vld) begin
        exp_sts <= TCB_OK;
        exp_dat <= (req_op == TCB_RD);
        for (int b = 0; b < `TCB_BEN; b++) begin
          exp_rdt[8*b +: 8] <= shadow[{wrd, 2'(b)}];
          // enabled lanes only
          if ((req_op == TCB_WR) && req_ben[b]) begin
            shadow[{wrd, 2'(b)}] <= req_wdt[8*b +: 8];
          end
        end
      end
    end
  end

////////////////////////////////////////////////////////////////////////////
// assertions
////////////////////////////////////////////////////////////////////////////

  // one response one cycle after every request
  a_rsp_after_req: assert property (
    @(posedge clk) disable iff (!rst_n) req_vld |=> rsp_vld
  ) else begin
    err_cnt = err_cnt + 1;
    $error("ERR %0t: no response one cycle after a request", $realtime);
  end

  // no response without a request
  a_no_rsp_idle: assert property (
    @(posedge clk) disable iff (!rst_n) !req_vld |=> !rsp_vld
  ) else begin
    err_cnt = err_cnt + 1;
    $error("ERR %0t: response without a request", $realtime);
  end

  // quiet bus when reset lifts
  a_rst_quiet: assert property (
    @(posedge clk) $rose(rst_n) |-> !rsp_vld
  ) else begin
    err_cnt = err_cnt + 1;
    $error("ERR %0t: response strobe high right after reset", $realtime);
  end

  // status matches the decode
  a_rsp_sts: assert property (
    @(posedge clk) disable iff (!rst_n) rsp_vld |-> (rsp_sts == exp_sts)
  ) else begin
    err_cnt = err_cnt + 1;
    $error("ERR %0t: status %0d, expected %0d", $realtime,
           $sampled(rsp_sts), $sampled(exp_sts));
  end

  // read data against the shadow, zero on a miss
  a_rsp_rdt: assert property (
    @(posedge clk) disable iff (!rst_n) (rsp_vld && exp_dat) |-> (rsp_rdt == exp_rdt)
  ) else begin
    err_cnt = err_cnt + 1;
    $error("ERR %0t: read data %h, expected %h", $realtime,
           $sampled(rsp_rdt), $sampled(exp_rdt));
  end

endmodule : tcb_ic_checker

// attach to every interconnect top
bind tcb_ic_top tcb_ic_checker tcb_ic_checker_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_vld (req_vld),
  .req_op  (req_op),
  .req_adr (req_adr),
  .req_ben (req_ben),
  .req_wdt (req_wdt),
  .rsp_vld (rsp_vld),
  .rsp_rdt (rsp_rdt),
  .rsp_sts (rsp_sts)
);

`default_nettype wire

//--- verif/tcb_ic_tb.sv
// TCB interconnect testbench driving reads, writes and misses on the manager port
`timescale 1ns/1ps
`default_nettype none

`include "tcb_params.svh"

module tcb_ic_tb
  import tcb_pkg::*;
();

  // about 750 requests plus idle gaps
  localparam int unsigned MAX_CYC = 2000;

  logic                clk;
  logic                rst_n;
  logic                req_vld;
  tcb_op_t             req_op;
  logic [`TCB_ADR-1:0] req_adr;
  logic [`TCB_BEN-1:0] req_ben;
  logic [`TCB_DAT-1:0] req_wdt;
  logic                rsp_vld;
  logic [`TCB_DAT-1:0] rsp_rdt;
  tcb_sts_t            rsp_sts;

  int unsigned cyc_cnt;
  int unsigned req_cnt;

  tcb_ic_top tcb_ic_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_op  (req_op),
    .req_adr (req_adr),
    .req_ben (req_ben),
    .req_wdt (req_wdt),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_sts (rsp_sts)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

////////////////////////////////////////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////////////////////////////////////////

  // one request, driven on the falling edge
  task automatic issue(input tcb_op_t op, input logic [31:0] adr,
                       input logic [3:0] ben, input logic [31:0] wdt);
    @(negedge clk);
    req_vld = 1'b1;
    req_op  = op;
    req_adr = adr;
    req_ben = ben;
    req_wdt = wdt;
    req_cnt++;
  endtask : issue

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(negedge clk);
      req_vld = 1'b0;
    end
  endtask : idle

  // same low bits, some upper bit set
  function automatic logic [31:0] miss_adr(input logic [9:0] low);
    logic [31:0] adr;
    adr = $urandom();
    if (adr[31:10] == '0) begin
      adr[10] = 1'b1;
    end
    adr[9:0] = low;
    return adr;
  endfunction : miss_adr

////////////////////////////////////////////////////////////////////////////
// test phases
////////////////////////////////////////////////////////////////////////////

  // every word of every window, back to back
  task automatic fill_all();
    for (int a = 0; a < 256; a++) begin
      issue(TCB_WR, 32'(a) << 2, 4'hf, $urandom());
    end
  endtask : fill_all

  // same offset in all windows, window number in the top byte
  task automatic check_isolation(input int unsigned n);
    logic [31:0] rnd;
    logic [7:0]  off;
    for (int k = 0; k < n; k++) begin
      rnd = $urandom();
      off = {rnd[5:0], 2'b00};
      for (int w = 0; w < `TCB_IFN; w++) begin
        issue(TCB_WR, {22'd0, 2'(w), off}, 4'hf, {8'(w), rnd[31:8]});
      end
      for (int w = 0; w < `TCB_IFN; w++) begin
        issue(TCB_RD, {22'd0, 2'(w), off}, 4'h0, '0);
      end
    end
  endtask : check_isolation

  // mixed reads and writes, random lanes, some misses and gaps
  task automatic random_traffic(input int unsigned n);
    tcb_op_t     op;
    logic [31:0] adr;
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      rnd = $urandom();
      op  = rnd[0] ? TCB_WR : TCB_RD;
      adr = {22'd0, rnd[13:4]};
      if ($urandom_range(9, 0) == 0) begin
        adr = miss_adr(adr[9:0]);
      end
      issue(op, adr, rnd[19:16], $urandom());
      if ($urandom_range(7, 0) == 0) begin
        idle($urandom_range(3, 1));
      end
    end
  endtask : random_traffic

  // missed read and write, then the in-map alias must be intact
  task automatic check_miss(input int unsigned n);
    logic [31:0] rnd;
    for (int k = 0; k < n; k++) begin
      rnd = $urandom();
      issue(TCB_RD, miss_adr(rnd[9:0]), 4'h0, '0);
      issue(TCB_WR, miss_adr(rnd[9:0]), rnd[13:10] | 4'h1, $urandom());
      issue(TCB_RD, {22'd0, rnd[9:0]}, 4'h0, '0);
    end
  endtask : check_miss

////////////////////////////////////////////////////////////////////////////
// main sequence and closing report
////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int unsigned err;
    void'($urandom(32'hce23));
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req_op  = TCB_RD;
    req_adr = '0;
    req_ben = '0;
    req_wdt = '0;
    req_cnt = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    idle(2);
    fill_all();
    idle(3);
    check_isolation(16);
    idle(1);
    random_traffic(300);
    check_miss(20);
    // let the last response reach the checker
    idle(3);
    err = tcb_ic_top_inst.tcb_ic_checker_inst.err_cnt;
    $display("%0d requests, %0d cycles, %0d errors", req_cnt, cyc_cnt, err);
    if (err == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end : main

  // cycle limit
  initial begin : watchdog
    cyc_cnt = 0;
    while (cyc_cnt < MAX_CYC) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("the run timed out after %0d cycles", MAX_CYC);
    $display("%0d requests, %0d errors before the timeout", req_cnt,
             tcb_ic_top_inst.tcb_ic_checker_inst.err_cnt);
    $display("Errors found");
    $finish;
  end : watchdog

endmodule : tcb_ic_tb

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/tcb_pkg.sv
hdl/tcb_lib_decoder.sv
hdl/tcb_lib_demux.sv
hdl/tcb_mem_sub.sv
hdl/tcb_lib_mux.sv
hdl/tcb_ic_top.sv
verif/tcb_ic_checker.sv
verif/tcb_ic_tb.sv
